// ==== hw/load_queue.sv ====
`timescale 1ns/10ps

module load_queue #(
    parameter int LQ_WAYS  = lq_pkg::LQ_WAYS_DEFAULT,
    parameter int LQ_DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
) (
    input  logic                                     clock,
    input  logic                                     rst,
    input  logic                                     flush,
    input  logic [LQ_WAYS-1:0]                       ld_en,
    input  lq_pkg::ld_size_e [LQ_WAYS-1:0]           ld_size,
    input  logic [LQ_WAYS-1:0]                       ld_signed,
    input  lq_pkg::rob_idx_t [LQ_WAYS-1:0]           ld_rob_idx,
    input  lq_pkg::prf_idx_t [LQ_WAYS-1:0]           ld_prf_idx,
    input  logic [LQ_WAYS-1:0][$clog2(LQ_DEPTH)-1:0] ld_sq_tail,
    input  logic [LQ_WAYS-1:0]                       alu_valid,
    input  lq_pkg::rob_idx_t [LQ_WAYS-1:0]           alu_rob_idx,
    input  lq_pkg::addr_t [LQ_WAYS-1:0]              alu_addr,
    input  logic [$clog2(LQ_DEPTH)-1:0]              sq_head,
    input  lq_pkg::addr_t [LQ_DEPTH-1:0]             sq_addr,
    input  lq_pkg::ld_size_e [LQ_DEPTH-1:0]          sq_size,
    input  lq_pkg::data_t [LQ_DEPTH-1:0]             sq_data,
    input  logic [LQ_DEPTH-1:0]                      sq_addr_valid,
    input  logic [LQ_DEPTH-1:0]                      sq_data_valid,
    input  lq_pkg::data_t                            wb_dat,
    input  logic                                     wb_ack,
    output logic                                     wb_cyc,
    output logic                                     wb_stb,
    output lq_pkg::addr_t                            wb_adr,
    output logic [3:0]                               wb_sel,
    output logic                                     cdb_valid,
    output lq_pkg::data_t                            cdb_data,
    output lq_pkg::rob_idx_t                         cdb_rob_idx,
    output lq_pkg::prf_idx_t                         cdb_prf_idx,
    output logic [$clog2(LQ_DEPTH+1)-1:0]            lq_num_free
);
    import lq_pkg::*;

    logic [LQ_DEPTH-1:0] free;
    logic [LQ_DEPTH-1:0] fwd;
    data_t [LQ_DEPTH-1:0] fwd_data;
    logic [LQ_DEPTH-1:0] ready;
    logic fill_valid;
    logic [$clog2(LQ_DEPTH)-1:0] fill_entry;
    data_t fill_data;
    logic [LQ_DEPTH-1:0] cdb_gnt;

    lq_alloc_if #(.DEPTH(LQ_DEPTH)) alloc_bus ();
    lq_status_if #(.DEPTH(LQ_DEPTH)) status_bus ();

    lq_alloc #(
        .LQ_WAYS(LQ_WAYS),
        .LQ_DEPTH(LQ_DEPTH)
    ) u_alloc (
        .ld_en(ld_en),
        .ld_size(ld_size),
        .ld_signed(ld_signed),
        .ld_rob_idx(ld_rob_idx),
        .ld_prf_idx(ld_prf_idx),
        .ld_sq_tail(ld_sq_tail),
        .free(free),
        .alloc(alloc_bus.alloc)
    );

    lq_entries #(
        .LQ_WAYS(LQ_WAYS),
        .LQ_DEPTH(LQ_DEPTH)
    ) u_entries (
        .clock(clock),
        .rst(rst),
        .flush(flush),
        .alloc(alloc_bus.entries),
        .alu_valid(alu_valid),
        .alu_rob_idx(alu_rob_idx),
        .alu_addr(alu_addr),
        .fwd(fwd),
        .fwd_data(fwd_data),
        .ready(ready),
        .fill_valid(fill_valid),
        .fill_entry(fill_entry),
        .fill_data(fill_data),
        .cdb_gnt(cdb_gnt),
        .status(status_bus.entries),
        .free(free),
        .lq_num_free(lq_num_free)
    );

    lq_store_check #(
        .LQ_DEPTH(LQ_DEPTH)
    ) u_check (
        .clock(clock),
        .rst(rst),
        .flush(flush),
        .status(status_bus.check),
        .sq_head(sq_head),
        .sq_addr(sq_addr),
        .sq_size(sq_size),
        .sq_data(sq_data),
        .sq_addr_valid(sq_addr_valid),
        .sq_data_valid(sq_data_valid),
        .fwd(fwd),
        .fwd_data(fwd_data),
        .ready(ready)
    );

    lq_cache_port #(
        .LQ_DEPTH(LQ_DEPTH)
    ) u_cache (
        .clock(clock),
        .rst(rst),
        .flush(flush),
        .ready(ready),
        .status(status_bus.cache),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_adr(wb_adr),
        .wb_sel(wb_sel),
        .wb_dat(wb_dat),
        .wb_ack(wb_ack),
        .fill_valid(fill_valid),
        .fill_entry(fill_entry),
        .fill_data(fill_data)
    );

    lq_writeback #(
        .LQ_DEPTH(LQ_DEPTH)
    ) u_writeback (
        .clock(clock),
        .rst(rst),
        .status(status_bus.writeback),
        .cdb_gnt(cdb_gnt),
        .cdb_valid(cdb_valid),
        .cdb_data(cdb_data),
        .cdb_rob_idx(cdb_rob_idx),
        .cdb_prf_idx(cdb_prf_idx)
    );

endmodule

// ==== hw/lq_alloc.sv ====
`timescale 1ns/10ps

module lq_alloc #(
    parameter int LQ_WAYS  = lq_pkg::LQ_WAYS_DEFAULT,
    parameter int LQ_DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
) (
    input  logic [LQ_WAYS-1:0]                       ld_en,
    input  lq_pkg::ld_size_e [LQ_WAYS-1:0]           ld_size,
    input  logic [LQ_WAYS-1:0]                       ld_signed,
    input  lq_pkg::rob_idx_t [LQ_WAYS-1:0]           ld_rob_idx,
    input  lq_pkg::prf_idx_t [LQ_WAYS-1:0]           ld_prf_idx,
    input  logic [LQ_WAYS-1:0][$clog2(LQ_DEPTH)-1:0] ld_sq_tail,
    input  logic [LQ_DEPTH-1:0]                      free,
    lq_alloc_if.alloc                                alloc
);
    import lq_pkg::*;

    // way k claims the k-th lowest free entry, writes only if enabled
    always_comb begin
        logic [LQ_DEPTH-1:0] avail;
        logic taken;
        avail = free;
        alloc.we = '0;
        alloc.is_signed = '0;
        alloc.rob = '0;
        alloc.prf = '0;
        alloc.tail = '0;
        for (int e = 0; e < LQ_DEPTH; e++) begin
            alloc.size[e] = BYTE;
        end
        for (int k = 0; k < LQ_WAYS; k++) begin
            taken = 1'b0;
            for (int e = 0; e < LQ_DEPTH; e++) begin
                if (avail[e] && !taken) begin
                    taken = 1'b1;
                    avail[e] = 1'b0;
                    if (ld_en[k]) begin
                        alloc.we[e] = 1'b1;
                        alloc.size[e] = ld_size[k];
                        alloc.is_signed[e] = ld_signed[k];
                        alloc.rob[e] = ld_rob_idx[k];
                        alloc.prf[e] = ld_prf_idx[k];
                        alloc.tail[e] = ld_sq_tail[k];
                    end
                end
            end
        end
    end

endmodule

// ==== hw/lq_cache_port.sv ====
`timescale 1ns/10ps

module lq_cache_port #(
    parameter int LQ_DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          flush,
    input  logic [LQ_DEPTH-1:0]           ready,
    lq_status_if.cache                    status,
    output logic                          wb_cyc,
    output logic                          wb_stb,
    output lq_pkg::addr_t                 wb_adr,
    output logic [3:0]                    wb_sel,
    input  lq_pkg::data_t                 wb_dat,
    input  logic                          wb_ack,
    output logic                          fill_valid,
    output logic [$clog2(LQ_DEPTH)-1:0]   fill_entry,
    output lq_pkg::data_t                 fill_data
);
    import lq_pkg::*;

    localparam int IDX_W = $clog2(LQ_DEPTH);

    logic [LQ_DEPTH-1:0] issued;
    logic [LQ_DEPTH-1:0] arb_req;
    logic [LQ_DEPTH-1:0] arb_gnt;
    logic [IDX_W-1:0] gnt_idx;
    logic [3:0] gnt_sel;
    // result of a flushed load is thrown away at ack
    logic drop;

    assign arb_req = (wb_cyc || flush) ? '0 : (ready & ~issued);

    rr_arbiter #(
        .WIDTH(LQ_DEPTH)
    ) u_arb (
        .clock(clock),
        .rst(rst),
        .req(arb_req),
        .gnt(arb_gnt)
    );

    always_comb begin
        gnt_idx = '0;
        for (int e = 0; e < LQ_DEPTH; e++) begin
            if (arb_gnt[e]) begin
                gnt_idx = IDX_W'(e);
            end
        end
        case (status.size[gnt_idx])
            BYTE:    gnt_sel = 4'b0001;
            HALF:    gnt_sel = 4'b0011;
            default: gnt_sel = 4'b1111;
        endcase
        gnt_sel = gnt_sel << status.addr[gnt_idx][1:0];
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            drop <= 1'b0;
            issued <= '0;
        end else begin
            if (wb_cyc && wb_ack) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
            end else if (arb_gnt != '0) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end
            drop <= wb_cyc && !wb_ack && (drop || flush);
            // an entry stays issued until its ready drops at free
            issued <= flush ? '0 : ((issued & ready) | arb_gnt);
        end
    end

    // request fields latch while idle and hold through the cycle
    always_ff @(posedge clock) begin
        if (!wb_cyc) begin
            fill_entry <= gnt_idx;
            wb_adr <= status.addr[gnt_idx];
            wb_sel <= gnt_sel;
        end
    end

    assign fill_valid = wb_cyc && wb_ack && !drop;
    assign fill_data = wb_dat;

endmodule

// ==== hw/lq_entries.sv ====
`timescale 1ns/10ps

module lq_entries #(
    parameter int LQ_WAYS  = lq_pkg::LQ_WAYS_DEFAULT,
    parameter int LQ_DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
) (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             flush,
    lq_alloc_if.entries                      alloc,
    input  logic [LQ_WAYS-1:0]               alu_valid,
    input  lq_pkg::rob_idx_t [LQ_WAYS-1:0]   alu_rob_idx,
    input  lq_pkg::addr_t [LQ_WAYS-1:0]      alu_addr,
    input  logic [LQ_DEPTH-1:0]              fwd,
    input  lq_pkg::data_t [LQ_DEPTH-1:0]     fwd_data,
    input  logic [LQ_DEPTH-1:0]              ready,
    input  logic                             fill_valid,
    input  logic [$clog2(LQ_DEPTH)-1:0]      fill_entry,
    input  lq_pkg::data_t                    fill_data,
    input  logic [LQ_DEPTH-1:0]              cdb_gnt,
    lq_status_if.entries                     status,
    output logic [LQ_DEPTH-1:0]              free,
    output logic [$clog2(LQ_DEPTH+1)-1:0]    lq_num_free
);
    import lq_pkg::*;

    localparam int IDX_W = $clog2(LQ_DEPTH);
    localparam int CNT_W = $clog2(LQ_DEPTH + 1);

    logic [LQ_DEPTH-1:0] addr_hit;
    addr_t [LQ_DEPTH-1:0] addr_new;
    logic [LQ_DEPTH-1:0] take_fwd;
    logic [LQ_DEPTH-1:0] fill_hit;
    logic [LQ_DEPTH-1:0] busy_next;
    logic [CNT_W-1:0] free_cnt;

    assign free = ~status.busy;

    // ALU result tagged with the ROB index of a waiting entry
    always_comb begin
        addr_hit = '0;
        addr_new = status.addr;
        for (int e = 0; e < LQ_DEPTH; e++) begin
            for (int k = 0; k < LQ_WAYS; k++) begin
                if (alu_valid[k] && alu_rob_idx[k] == status.rob[e] &&
                        status.busy[e] && !status.addr_ready[e]) begin
                    addr_hit[e] = 1'b1;
                    addr_new[e] = alu_addr[k];
                end
            end
        end
    end

    // results only land on live entries still waiting for data
    always_comb begin
        for (int e = 0; e < LQ_DEPTH; e++) begin
            take_fwd[e] = status.busy[e] && status.addr_ready[e] && !status.done[e] && fwd[e];
            fill_hit[e] = status.busy[e] && status.addr_ready[e] && !status.done[e] &&
                          ready[e] && fill_valid && fill_entry == IDX_W'(e);
        end
    end

    assign busy_next = (status.busy & ~cdb_gnt) | alloc.we;
    assign free_cnt = CNT_W'($countones(~busy_next));

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            status.busy <= '0;
            status.addr_ready <= '0;
            status.done <= '0;
            lq_num_free <= CNT_W'(LQ_DEPTH);
        end else begin
            status.busy <= busy_next;
            status.addr_ready <= (status.addr_ready | addr_hit) & ~cdb_gnt & ~alloc.we;
            status.done <= (status.done | take_fwd | fill_hit) & ~cdb_gnt & ~alloc.we;
            // issuer sees zero once a full group no longer fits
            lq_num_free <= (free_cnt < LQ_WAYS) ? '0 : free_cnt;
        end
    end

    always_ff @(posedge clock) begin
        for (int e = 0; e < LQ_DEPTH; e++) begin
            if (alloc.we[e]) begin
                status.size[e] <= alloc.size[e];
                status.is_signed[e] <= alloc.is_signed[e];
                status.rob[e] <= alloc.rob[e];
                status.prf[e] <= alloc.prf[e];
                status.tail[e] <= alloc.tail[e];
            end
            if (addr_hit[e]) begin
                status.addr[e] <= addr_new[e];
            end
            if (take_fwd[e]) begin
                status.data[e] <= fwd_data[e];
            end else if (fill_hit[e]) begin
                status.data[e] <= fill_data;
            end
        end
    end

    a_gnt_busy: assert property (@(posedge clock) disable iff (rst)
        (cdb_gnt & ~status.busy) == '0)
        else $error("CDB grant to a free load queue entry");

    a_alloc_fits: assert property (@(posedge clock) disable iff (rst)
        $countones(alloc.we) <= lq_num_free)
        else $error("more loads allocated than free entries");

endmodule

// ==== hw/lq_ifs.sv ====
`timescale 1ns/10ps

// allocator to entry array, one slot per entry
interface lq_alloc_if #(
    parameter int DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
);
    import lq_pkg::*;

    localparam int SQ_W = $clog2(DEPTH);

    logic [DEPTH-1:0] we;
    ld_size_e [DEPTH-1:0] size;
    logic [DEPTH-1:0] is_signed;
    rob_idx_t [DEPTH-1:0] rob;
    prf_idx_t [DEPTH-1:0] prf;
    logic [DEPTH-1:0][SQ_W-1:0] tail;

    modport alloc (output we, size, is_signed, rob, prf, tail);
    modport entries (input we, size, is_signed, rob, prf, tail);
endinterface

// per-entry state, read by the check, cache and writeback blocks
interface lq_status_if #(
    parameter int DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
);
    import lq_pkg::*;

    localparam int SQ_W = $clog2(DEPTH);

    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] addr_ready;
    logic [DEPTH-1:0] done;
    logic [DEPTH-1:0] is_signed;
    addr_t [DEPTH-1:0] addr;
    ld_size_e [DEPTH-1:0] size;
    rob_idx_t [DEPTH-1:0] rob;
    prf_idx_t [DEPTH-1:0] prf;
    logic [DEPTH-1:0][SQ_W-1:0] tail;
    data_t [DEPTH-1:0] data;

    modport entries (output busy, addr_ready, done, is_signed, addr, size, rob, prf, tail, data);
    modport check (input busy, addr_ready, addr, size, tail);
    modport cache (input addr, size);
    modport writeback (input done, data, size, is_signed, rob, prf);
endinterface

// ==== hw/lq_pkg.sv ====
package lq_pkg;

    // 16-bit data address, block is [15:3], offset is [2:0]
    typedef logic [15:0] addr_t;

    typedef logic [31:0] data_t;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } ld_size_e;

    typedef logic [4:0] rob_idx_t;
    typedef logic [5:0] prf_idx_t;

    // loads issued per cycle
    localparam int LQ_WAYS_DEFAULT = 2;
    // entries in both the load queue and the store queue
    localparam int LQ_DEPTH_DEFAULT = 8;

endpackage

// ==== hw/lq_store_check.sv ====
`timescale 1ns/10ps

module lq_store_check #(
    parameter int LQ_DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
) (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             flush,
    lq_status_if.check                       status,
    input  logic [$clog2(LQ_DEPTH)-1:0]      sq_head,
    input  lq_pkg::addr_t [LQ_DEPTH-1:0]     sq_addr,
    input  lq_pkg::ld_size_e [LQ_DEPTH-1:0]  sq_size,
    input  lq_pkg::data_t [LQ_DEPTH-1:0]     sq_data,
    input  logic [LQ_DEPTH-1:0]              sq_addr_valid,
    input  logic [LQ_DEPTH-1:0]              sq_data_valid,
    output logic [LQ_DEPTH-1:0]              fwd,
    output lq_pkg::data_t [LQ_DEPTH-1:0]     fwd_data,
    output logic [LQ_DEPTH-1:0]              ready
);
    localparam int IDX_W = $clog2(LQ_DEPTH);

    logic [LQ_DEPTH-1:0] ready_d;

    // walk back from the tail snapshot, first block match is the youngest older store
    always_comb begin
        logic [IDX_W-1:0] span;
        logic [IDX_W-1:0] idx;
        logic [IDX_W-1:0] sel;
        logic found;
        logic pending;
        fwd = '0;
        fwd_data = '0;
        ready_d = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            // number of stores older than load i
            span = status.tail[i] - sq_head;
            sel = '0;
            found = 1'b0;
            pending = 1'b0;
            for (int d = 1; d <= LQ_DEPTH; d++) begin
                idx = status.tail[i] - IDX_W'(d);
                if (d <= span) begin
                    if (!sq_addr_valid[idx]) begin
                        pending = 1'b1;
                    end else if (!found && sq_addr[idx][15:3] == status.addr[i][15:3]) begin
                        found = 1'b1;
                        sel = idx;
                    end
                end
            end
            if (status.busy[i] && status.addr_ready[i] && !pending) begin
                if (!found) begin
                    ready_d[i] = 1'b1;
                end else if (sq_addr[sel][2:0] == status.addr[i][2:0] &&
                        sq_size[sel] == status.size[i] && sq_data_valid[sel]) begin
                    fwd[i] = 1'b1;
                    fwd_data[i] = sq_data[sel];
                end
                // otherwise a partial overlap, hold until the store leaves
            end
        end
    end

    // forwarded data is registered in the entry, cache readiness here
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            ready <= '0;
        end else begin
            ready <= ready_d;
        end
    end

endmodule

// ==== hw/lq_writeback.sv ====
`timescale 1ns/10ps

module lq_writeback #(
    parameter int LQ_DEPTH = lq_pkg::LQ_DEPTH_DEFAULT
) (
    input  logic                  clock,
    input  logic                  rst,
    lq_status_if.writeback        status,
    output logic [LQ_DEPTH-1:0]   cdb_gnt,
    output logic                  cdb_valid,
    output lq_pkg::data_t         cdb_data,
    output lq_pkg::rob_idx_t      cdb_rob_idx,
    output lq_pkg::prf_idx_t      cdb_prf_idx
);
    import lq_pkg::*;

    data_t raw;
    ld_size_e size;
    logic sext;

    rr_arbiter #(
        .WIDTH(LQ_DEPTH)
    ) u_arb (
        .clock(clock),
        .rst(rst),
        .req(status.done),
        .gnt(cdb_gnt)
    );

    assign cdb_valid = |cdb_gnt;

    always_comb begin
        raw = '0;
        size = BYTE;
        sext = 1'b0;
        cdb_rob_idx = '0;
        cdb_prf_idx = '0;
        for (int e = 0; e < LQ_DEPTH; e++) begin
            if (cdb_gnt[e]) begin
                raw = status.data[e];
                size = status.size[e];
                sext = status.is_signed[e];
                cdb_rob_idx = status.rob[e];
                cdb_prf_idx = status.prf[e];
            end
        end
        // data is right-aligned, fill the upper bits by size and sign
        case (size)
            BYTE:    cdb_data = {{24{sext & raw[7]}}, raw[7:0]};
            HALF:    cdb_data = {{16{sext & raw[15]}}, raw[15:0]};
            default: cdb_data = raw;
        endcase
    end

endmodule

// ==== hw/rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int WIDTH = 8
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);
    localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // search starts one past the last winner
    logic [PTR_W-1:0] ptr;

    always_comb begin
        int idx;
        logic found;
        gnt = '0;
        found = 1'b0;
        for (int k = 0; k < WIDTH; k++) begin
            idx = (int'(ptr) + k) % WIDTH;
            if (req[idx] && !found) begin
                gnt[idx] = 1'b1;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ptr <= '0;
        end else begin
            for (int e = 0; e < WIDTH; e++) begin
                if (gnt[e]) begin
                    ptr <= PTR_W'((e + 1) % WIDTH);
                end
            end
        end
    end

    a_gnt_onehot: assert property (@(posedge clock) disable iff (rst)
        $onehot0(gnt) && (gnt & ~req) == '0)
        else $error("arbiter grant not one-hot within request");

endmodule

// ==== tests/tb_vectors.svh ====
// one row per scenario, per-way fields are written {way 1, way 0}
// src per way: 0 memory word, 1 store slot s0, 2 store slot s1
typedef struct packed {
    logic [1:0]       en;
    logic [1:0]       sgn;
    logic [1:0][1:0]  size;
    logic [1:0][4:0]  rob;
    logic [1:0][2:0]  tail;
    logic [1:0][15:0] addr;
    logic [2:0]       head;
    logic [2:0]       late_head;
    logic             late;
    logic             flush;
    logic [2:0]       s0_idx;
    logic [15:0]      s0_addr;
    logic [1:0]       s0_size;
    logic [31:0]      s0_data;
    logic             s0_av;
    logic [2:0]       s1_idx;
    logic [15:0]      s1_addr;
    logic [1:0]       s1_size;
    logic [31:0]      s1_data;
    logic             s1_av;
    logic [1:0][1:0]  src;
    logic [3:0]       reads;
} vec_t;

localparam int NUM_ROWS = 6;

vec_t rows [NUM_ROWS];

task automatic load_rows();
    // two cache loads, unsigned byte and signed half
    rows[0] = '{2'b11, 2'b10, {2'd1, 2'd0}, {5'd2, 5'd1}, {3'd0, 3'd0},
        {16'h9232, 16'h0105}, 3'd0, 3'd0, 1'b0, 1'b0,
        3'd0, 16'hFFF8, 2'd2, 32'h0, 1'b1, 3'd1, 16'hFFF8, 2'd2, 32'h0, 1'b1,
        {2'd0, 2'd0}, 4'd2};
    // way 0 forwards from slot 0, way 1 misses both stores
    rows[1] = '{2'b11, 2'b10, {2'd0, 2'd2}, {5'd6, 5'd5}, {3'd2, 3'd2},
        {16'h0600, 16'h0400}, 3'd0, 3'd0, 1'b0, 1'b0,
        3'd0, 16'h0400, 2'd2, 32'hDEADBEEF, 1'b1, 3'd1, 16'h2000, 2'd2, 32'h0, 1'b1,
        {2'd0, 2'd1}, 4'd1};
    // youngest of two matches, way 1 older than both stores
    rows[2] = '{2'b11, 2'b11, {2'd1, 2'd1}, {5'd8, 5'd7}, {3'd7, 3'd1},
        {16'h0808, 16'h0808}, 3'd6, 3'd6, 1'b0, 1'b0,
        3'd7, 16'h0808, 2'd1, 32'h11118001, 1'b1, 3'd0, 16'h0808, 2'd1, 32'h2222F0F0, 1'b1,
        {2'd0, 2'd2}, 4'd1};
    // older store without an address, forwards once it has one
    rows[3] = '{2'b01, 2'b01, {2'd0, 2'd0}, {5'd10, 5'd9}, {3'd0, 3'd1},
        {16'h0000, 16'h0A00}, 3'd0, 3'd0, 1'b1, 1'b0,
        3'd0, 16'h0A00, 2'd0, 32'h00000085, 1'b0, 3'd5, 16'hFFF8, 2'd2, 32'h0, 1'b1,
        {2'd0, 2'd1}, 4'd0};
    // partial overlap, store retires and the load reads memory
    rows[4] = '{2'b01, 2'b00, {2'd0, 2'd1}, {5'd12, 5'd11}, {3'd0, 3'd4},
        {16'h0000, 16'h0C00}, 3'd3, 3'd4, 1'b1, 1'b0,
        3'd3, 16'h0C04, 2'd2, 32'h12345678, 1'b1, 3'd5, 16'hFFF8, 2'd2, 32'h0, 1'b1,
        {2'd0, 2'd0}, 4'd1};
    // held loads are flushed and never broadcast
    rows[5] = '{2'b11, 2'b00, {2'd2, 2'd2}, {5'd14, 5'd13}, {3'd1, 3'd1},
        {16'h0E00, 16'h0E00}, 3'd0, 3'd0, 1'b0, 1'b1,
        3'd0, 16'h0E00, 2'd2, 32'h0, 1'b0, 3'd5, 16'hFFF8, 2'd2, 32'h0, 1'b1,
        {2'd0, 2'd0}, 4'd0};
endtask

// ==== tests/tb_load_queue.sv ====
`timescale 1ns/10ps

module tb_load_queue;
    import lq_pkg::*;

    `include "tb_vectors.svh"

    localparam int WATCH_CYCLES = (NUM_ROWS + 1) * 200;

    logic clock = 1'b0;
    logic rst;
    logic flush;
    logic [1:0] ld_en;
    ld_size_e [1:0] ld_size;
    logic [1:0] ld_signed;
    rob_idx_t [1:0] ld_rob_idx;
    prf_idx_t [1:0] ld_prf_idx;
    logic [1:0][2:0] ld_sq_tail;
    logic [1:0] alu_valid;
    rob_idx_t [1:0] alu_rob_idx;
    addr_t [1:0] alu_addr;
    logic [2:0] sq_head;
    addr_t [7:0] sq_addr;
    ld_size_e [7:0] sq_size;
    data_t [7:0] sq_data;
    logic [7:0] sq_addr_valid;
    logic [7:0] sq_data_valid;
    data_t wb_dat;
    logic wb_ack;
    logic wb_cyc;
    logic wb_stb;
    addr_t wb_adr;
    logic [3:0] wb_sel;
    logic cdb_valid;
    data_t cdb_data;
    rob_idx_t cdb_rob_idx;
    prf_idx_t cdb_prf_idx;
    logic [3:0] lq_num_free;

    // broadcasts collected by ROB index
    logic got_seen [32];
    data_t got_data [32];
    prf_idx_t got_prf [32];
    int bcast_count = 0;
    int read_count = 0;

    load_queue u_dut (.*);

    always #20 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    function automatic data_t mem_word(input addr_t a);
        return {a, a ^ 16'hA5C3};
    endfunction

    // keep the selected bytes and shift the lowest one to bit 0
    function automatic data_t sel_read(input addr_t a, input logic [3:0] sel);
        data_t w;
        int low;
        w = mem_word(a);
        low = 0;
        for (int b = 3; b >= 0; b--) begin
            if (!sel[b]) begin
                w[8*b +: 8] = 8'h00;
            end else begin
                low = b;
            end
        end
        return w >> (8 * low);
    endfunction

    // push the access to the top and shift it back down by sign or zero
    function automatic data_t extend(input data_t w, input logic [1:0] size, input logic sgn);
        int sh;
        sh = (size == 2'd0) ? 24 : (size == 2'd1) ? 16 : 0;
        if (sgn) begin
            return data_t'($signed(w << sh) >>> sh);
        end else begin
            return (w << sh) >> sh;
        end
    endfunction

    // wishbone memory with 0 to 3 wait cycles
    initial begin
        int unsigned waits;
        void'($urandom(53430));
        forever begin
            @(posedge clock);
            if (wb_cyc && wb_stb && !rst) begin
                waits = $urandom % 4;
                repeat (waits) @(posedge clock);
                #1;
                wb_dat = sel_read(wb_adr, wb_sel);
                wb_ack = 1'b1;
                read_count++;
                @(posedge clock);
                #1;
                wb_ack = 1'b0;
                wb_dat = '0;
            end
        end
    end

    always @(posedge clock) begin
        if (!rst && cdb_valid) begin
            got_seen[cdb_rob_idx] = 1'b1;
            got_data[cdb_rob_idx] = cdb_data;
            got_prf[cdb_rob_idx] = cdb_prf_idx;
            bcast_count++;
        end
    end

    initial begin
        #(WATCH_CYCLES * 40);
        $display("timeout: the DUT stopped making progress");
        $display("tests failed");
        $fatal(1);
    end

    task automatic apply_stores(input vec_t row, input logic release_all);
        for (int s = 0; s < 8; s++) begin
            sq_addr[s] = 16'hFFF8;
            sq_size[s] = WORD;
            sq_data[s] = 32'h5A5A0000 | s;
        end
        sq_addr_valid = '1;
        sq_data_valid = '1;
        sq_addr[row.s0_idx] = row.s0_addr;
        sq_size[row.s0_idx] = ld_size_e'(row.s0_size);
        sq_data[row.s0_idx] = row.s0_data;
        sq_addr_valid[row.s0_idx] = row.s0_av | release_all;
        sq_addr[row.s1_idx] = row.s1_addr;
        sq_size[row.s1_idx] = ld_size_e'(row.s1_size);
        sq_data[row.s1_idx] = row.s1_data;
        sq_addr_valid[row.s1_idx] = row.s1_av | release_all;
        sq_head = release_all ? row.late_head : row.head;
    endtask

    task automatic run_row(input vec_t row);
        int exp_count;
        int base_reads;
        data_t exp;
        rob_idx_t r;
        exp_count = row.flush ? 0 : $countones(row.en);
        base_reads = read_count;
        bcast_count = 0;
        for (int n = 0; n < 32; n++) begin
            got_seen[n] = 1'b0;
        end
        apply_stores(row, 1'b0);
        for (int k = 0; k < 2; k++) begin
            ld_en[k] = row.en[k];
            ld_size[k] = ld_size_e'(row.size[k]);
            ld_signed[k] = row.sgn[k];
            ld_rob_idx[k] = row.rob[k];
            ld_prf_idx[k] = {1'b1, row.rob[k]};
            ld_sq_tail[k] = row.tail[k];
        end
        @(posedge clock);
        #1;
        ld_en = '0;
        alu_valid = row.en;
        alu_rob_idx = row.rob;
        alu_addr = row.addr;
        @(posedge clock);
        #1;
        alu_valid = '0;
        if (row.late || row.flush) begin
            repeat (10) @(posedge clock);
            #1;
            check_value("cdb_valid count while held", bcast_count, 0);
            if (row.flush) begin
                flush = 1'b1;
                @(posedge clock);
                #1;
                flush = 1'b0;
            end
            apply_stores(row, 1'b1);
        end
        while (bcast_count < exp_count) begin
            @(posedge clock);
            #1;
        end
        repeat (10) @(posedge clock);
        #1;
        check_value("cdb_valid count", bcast_count, exp_count);
        check_value("wishbone reads", read_count - base_reads, row.reads);
        check_value("lq_num_free", lq_num_free, 8);
        for (int k = 0; k < 2; k++) begin
            if (row.en[k] && !row.flush) begin
                r = row.rob[k];
                if (row.src[k] == 2'd1) begin
                    exp = extend(row.s0_data, row.size[k], row.sgn[k]);
                end else if (row.src[k] == 2'd2) begin
                    exp = extend(row.s1_data, row.size[k], row.sgn[k]);
                end else begin
                    exp = extend(mem_word(row.addr[k]) >> (8 * row.addr[k][1:0]),
                                 row.size[k], row.sgn[k]);
                end
                check_value("cdb_rob_idx seen", got_seen[r], 1);
                check_value("cdb_data", got_data[r], exp);
                check_value("cdb_prf_idx", got_prf[r], {1'b1, r});
            end
        end
    endtask

    // fill without addresses until fewer than two entries are free and then flush
    task automatic fill_and_flush();
        int exp_free [4];
        exp_free = '{6, 4, 2, 0};
        bcast_count = 0;
        ld_sq_tail = '0;
        sq_head = '0;
        for (int c = 0; c < 4; c++) begin
            ld_en = (c == 3) ? 2'b01 : 2'b11;
            ld_rob_idx[0] = 5'(20 + 2 * c);
            ld_rob_idx[1] = 5'(21 + 2 * c);
            @(posedge clock);
            #1;
            check_value("lq_num_free", lq_num_free, exp_free[c]);
        end
        ld_en = '0;
        flush = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
        // addresses for two of the flushed loads must find no entry
        alu_valid = 2'b11;
        alu_rob_idx[0] = 5'd20;
        alu_rob_idx[1] = 5'd21;
        alu_addr[0] = 16'h0020;
        alu_addr[1] = 16'h0010;
        @(posedge clock);
        #1;
        alu_valid = '0;
        repeat (10) @(posedge clock);
        #1;
        check_value("cdb_valid count after flush", bcast_count, 0);
        check_value("lq_num_free", lq_num_free, 8);
    endtask

    initial begin
        load_rows();
        rst = 1'b1;
        flush = 1'b0;
        ld_en = '0;
        ld_size = '0;
        ld_signed = '0;
        ld_rob_idx = '0;
        ld_prf_idx = '0;
        ld_sq_tail = '0;
        alu_valid = '0;
        alu_rob_idx = '0;
        alu_addr = '0;
        sq_head = '0;
        sq_addr = '0;
        sq_size = '0;
        sq_data = '0;
        sq_addr_valid = '0;
        sq_data_valid = '0;
        wb_dat = '0;
        wb_ack = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;
        check_value("lq_num_free", lq_num_free, 8);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        fill_and_flush();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+tests
hw/lq_pkg.sv
hw/lq_ifs.sv
hw/rr_arbiter.sv
hw/lq_alloc.sv
hw/lq_entries.sv
hw/lq_store_check.sv
hw/lq_cache_port.sv
hw/lq_writeback.sv
hw/load_queue.sv
tests/tb_load_queue.sv
